//--- rv_exec_consts.svh
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

`define XLEN 64

// major opcodes
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_32     7'b0111011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_BRANCH    7'b1100011

`define F7_MULDIV 7'b0000001 // m extension
`define F7_ALT    7'b0100000 // sub / sra

// restoring divider iterations
`define DIV_STEPS_D 64
`define DIV_STEPS_W 32

`endif

//--- rv_exec_pkg.sv
`default_nettype none

`include "rv_exec_consts.svh"

package rv_exec_pkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_MUL,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_DIV,
        ALU_DIVU,
        ALU_REM,
        ALU_REMU
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // same instruction word, two field layouts
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } insn_u;

    typedef struct packed {
        alu_op_e          op;
        logic             word;   // 32-bit form
        logic             is_div;
        logic [`XLEN-1:0] src1;
        logic [`XLEN-1:0] src2;
    } alu_req_t;

    typedef struct packed {
        logic             valid;
        logic             taken;
        logic [`XLEN-1:0] rd_val;
    } exec_rsp_t;

endpackage

`default_nettype wire

//--- exec_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module exec_decoder (
    input  rv_exec_pkg::insn_u    insn,
    input  logic [`XLEN-1:0]      rs1_val,
    input  logic [`XLEN-1:0]      rs2_val,
    output rv_exec_pkg::alu_req_t req
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 alt;
    logic                 is_imm;
    logic                 word;
    logic                 is_div;
    logic                 zext;
    logic [`XLEN-1:0]     imm_sext;
    logic [`XLEN-1:0]     shamt;
    logic [`XLEN-1:0]     src1;
    logic [`XLEN-1:0]     src2;
    rv_exec_pkg::alu_op_e op;

    assign opcode   = insn.r.opcode;
    assign funct3   = insn.r.funct3;
    assign alt      = insn.r.funct7[5]; // also imm[10] of srai
    assign is_imm   = (opcode == `OPC_OP_IMM) || (opcode == `OPC_OP_IMM_32);
    assign word     = (opcode == `OPC_OP_32) || (opcode == `OPC_OP_IMM_32);
    assign imm_sext = {{(`XLEN-12){insn.i.imm[11]}}, insn.i.imm};

    // shamt sits in rs2 plus funct7[0] for 64-bit shifts
    assign shamt = word ? {{(`XLEN-5){1'b0}}, insn.r.rs2}
                        : {{(`XLEN-6){1'b0}}, insn.r.funct7[0], insn.r.rs2};

    always_comb begin
        op = rv_exec_pkg::ALU_ADD;
        if (opcode == `OPC_BRANCH) begin
            case (funct3)
                3'b000:  op = rv_exec_pkg::ALU_BEQ;
                3'b001:  op = rv_exec_pkg::ALU_BNE;
                3'b100:  op = rv_exec_pkg::ALU_BLT;
                3'b101:  op = rv_exec_pkg::ALU_BGE;
                3'b110:  op = rv_exec_pkg::ALU_BLTU;
                default: op = rv_exec_pkg::ALU_BGEU;
            endcase
        end else if (!is_imm && insn.r.funct7 == `F7_MULDIV) begin
            case (funct3)
                3'b100:  op = rv_exec_pkg::ALU_DIV;
                3'b101:  op = rv_exec_pkg::ALU_DIVU;
                3'b110:  op = rv_exec_pkg::ALU_REM;
                3'b111:  op = rv_exec_pkg::ALU_REMU;
                default: op = rv_exec_pkg::ALU_MUL; // no mulh variants
            endcase
        end else begin
            case (funct3)
                3'b000:  op = (alt && !is_imm) ? rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
                3'b001:  op = rv_exec_pkg::ALU_SLL;
                3'b010:  op = rv_exec_pkg::ALU_SLT;
                3'b011:  op = rv_exec_pkg::ALU_SLTU;
                3'b100:  op = rv_exec_pkg::ALU_XOR;
                3'b101:  op = alt ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
                3'b110:  op = rv_exec_pkg::ALU_OR;
                default: op = rv_exec_pkg::ALU_AND;
            endcase
        end
    end

    assign is_div = op inside {rv_exec_pkg::ALU_DIV, rv_exec_pkg::ALU_DIVU,
                               rv_exec_pkg::ALU_REM, rv_exec_pkg::ALU_REMU};
    // unsigned word ops see the low half zero-extended
    assign zext   = word && (op inside {rv_exec_pkg::ALU_DIVU, rv_exec_pkg::ALU_REMU,
                                        rv_exec_pkg::ALU_SRL});

    always_comb begin
        src1 = rs1_val;
        src2 = rs2_val;
        if (is_imm) begin
            src2 = (op inside {rv_exec_pkg::ALU_SLL, rv_exec_pkg::ALU_SRL,
                               rv_exec_pkg::ALU_SRA}) ? shamt : imm_sext;
        end
        if (word) begin
            src1 = zext ? {{(`XLEN-32){1'b0}}, src1[31:0]}
                        : {{(`XLEN-32){src1[31]}}, src1[31:0]};
            src2 = zext ? {{(`XLEN-32){1'b0}}, src2[31:0]}
                        : {{(`XLEN-32){src2[31]}}, src2[31:0]};
        end
    end

    assign req = '{op: op, word: word, is_div: is_div, src1: src1, src2: src2};

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module alu (
    input  rv_exec_pkg::alu_req_t req,
    output logic [`XLEN-1:0]      alu_res,
    output logic                  cmp_true
);

    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    logic [5:0]       shamt;
    logic             lt_s;
    logic             lt_u;
    logic             eq;
    logic [`XLEN-1:0] raw;

    assign src1  = req.src1;
    assign src2  = req.src2;
    assign shamt = req.word ? {1'b0, src2[4:0]} : src2[5:0]; // 5 bits for w forms

    // shared by slt/sltu and the branches
    assign lt_s = $signed(src1) < $signed(src2);
    assign lt_u = src1 < src2;
    assign eq   = src1 == src2;

    always_comb begin
        case (req.op)
            rv_exec_pkg::ALU_ADD:  raw = src1 + src2;
            rv_exec_pkg::ALU_SUB:  raw = src1 - src2;
            rv_exec_pkg::ALU_AND:  raw = src1 & src2;
            rv_exec_pkg::ALU_OR:   raw = src1 | src2;
            rv_exec_pkg::ALU_XOR:  raw = src1 ^ src2;
            rv_exec_pkg::ALU_SLL:  raw = src1 << shamt;
            rv_exec_pkg::ALU_SRL:  raw = src1 >> shamt;           // srlw src1 is zext
            rv_exec_pkg::ALU_SRA:  raw = $signed(src1) >>> shamt; // sraw src1 is sext
            rv_exec_pkg::ALU_SLT:  raw = {{(`XLEN-1){1'b0}}, lt_s};
            rv_exec_pkg::ALU_SLTU: raw = {{(`XLEN-1){1'b0}}, lt_u};
            rv_exec_pkg::ALU_MUL:  raw = src1 * src2;             // low half only
            default:               raw = '0;                      // branches, divides
        endcase
    end

    always_comb begin
        case (req.op)
            rv_exec_pkg::ALU_BEQ:  cmp_true = eq;
            rv_exec_pkg::ALU_BNE:  cmp_true = !eq;
            rv_exec_pkg::ALU_BLT:  cmp_true = lt_s;
            rv_exec_pkg::ALU_BGE:  cmp_true = !lt_s;
            rv_exec_pkg::ALU_BLTU: cmp_true = lt_u;
            rv_exec_pkg::ALU_BGEU: cmp_true = !lt_u;
            default:               cmp_true = 1'b0;
        endcase
    end

    // w forms return bit 31 extended
    assign alu_res = req.word ? {{(`XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

//--- exec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module exec_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue,
    input  rv_exec_pkg::alu_req_t  req,
    input  logic [`XLEN-1:0]       alu_res,
    input  logic                   cmp_true,
    input  logic                   last_step,
    input  logic [`XLEN-1:0]       div_res,
    output logic                   div_start,
    output logic                   div_step,
    output logic                   busy,
    output rv_exec_pkg::exec_rsp_t rsp
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DIV,
        S_RESP
    } state_e;

    state_e           state;
    logic             accept_alu;
    logic             is_branch;
    logic             rsp_valid;
    logic             rsp_taken;
    logic [`XLEN-1:0] rsp_val;

    assign is_branch  = req.op inside {rv_exec_pkg::ALU_BEQ, rv_exec_pkg::ALU_BNE,
                                       rv_exec_pkg::ALU_BLT, rv_exec_pkg::ALU_BGE,
                                       rv_exec_pkg::ALU_BLTU, rv_exec_pkg::ALU_BGEU};
    assign accept_alu = issue && (state == S_IDLE) && !req.is_div;
    assign div_start  = issue && (state == S_IDLE) && req.is_div;
    assign div_step   = (state == S_DIV);
    assign busy       = (state != S_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0; // one-cycle pulse
            case (state)
                S_IDLE: begin
                    if (div_start) begin
                        state <= S_DIV;
                    end else if (accept_alu) begin
                        rsp_valid <= 1'b1;
                    end
                end
                S_DIV: begin
                    if (last_step) begin
                        state <= S_RESP; // div_res settles after the last step
                    end
                end
                default: begin
                    rsp_valid <= 1'b1;
                    state     <= S_IDLE;
                end
            endcase
        end
    end

    // holds between responses
    always_ff @(posedge clk) begin
        if (accept_alu) begin
            rsp_taken <= is_branch && cmp_true;
            rsp_val   <= is_branch ? '0 : alu_res;
        end else if (state == S_RESP) begin
            rsp_taken <= 1'b0;
            rsp_val   <= div_res;
        end
    end

    assign rsp = '{valid: rsp_valid, taken: rsp_taken, rd_val: rsp_val};

endmodule

`default_nettype wire

//--- div_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module div_step_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic word,
    input  logic step,
    output logic last_step
);

    logic [6:0] count; // iterations left

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= word ? 7'(`DIV_STEPS_W) : 7'(`DIV_STEPS_D);
        end else if (step && count != '0) begin
            count <= count - 7'd1;
        end
    end

    assign last_step = step && (count == 7'd1);

endmodule

`default_nettype wire

//--- div_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module div_datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  step,
    input  rv_exec_pkg::alu_req_t req,
    output logic [`XLEN-1:0]      div_res
);

    logic             sgn_op;
    logic             neg1;
    logic             neg2;
    logic [`XLEN-1:0] mag1;
    logic [`XLEN-1:0] mag2;
    logic [`XLEN-1:0] min_neg;
    logic             dz;
    logic             ovf;
    logic             want_rem;
    logic             word_q;
    logic             q_neg;
    logic             r_neg;
    logic             dz_q;
    logic             ovf_q;
    logic [`XLEN-1:0] dividend;
    logic [`XLEN-1:0] divisor;
    logic [`XLEN-1:0] quo;
    logic [`XLEN-1:0] rem;
    logic [`XLEN:0]   rem_sh;
    logic [`XLEN:0]   trial;
    logic [`XLEN-1:0] q_fix;
    logic [`XLEN-1:0] r_fix;
    logic [`XLEN-1:0] res;

    assign sgn_op  = req.op inside {rv_exec_pkg::ALU_DIV, rv_exec_pkg::ALU_REM};
    assign neg1    = sgn_op && req.src1[`XLEN-1];
    assign neg2    = sgn_op && req.src2[`XLEN-1];
    assign mag1    = neg1 ? -req.src1 : req.src1;
    assign mag2    = neg2 ? -req.src2 : req.src2;
    assign min_neg = req.word ? {{(`XLEN-31){1'b1}}, 31'b0} : {1'b1, {(`XLEN-1){1'b0}}};
    assign dz      = (req.src2 == '0);
    assign ovf     = sgn_op && (req.src1 == min_neg) && (&req.src2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {want_rem, word_q, q_neg, r_neg, dz_q, ovf_q} <= '0;
        end else if (start) begin
            want_rem <= req.op inside {rv_exec_pkg::ALU_REM, rv_exec_pkg::ALU_REMU};
            word_q   <= req.word;
            q_neg    <= neg1 ^ neg2;
            r_neg    <= neg1; // remainder follows the dividend
            dz_q     <= dz;
            ovf_q    <= ovf;
        end
    end

    // one shift-compare-subtract per step
    assign rem_sh = {rem, quo[`XLEN-1]};
    assign trial  = rem_sh - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (start) begin
            dividend <= req.src1;
            divisor  <= mag2;
            rem      <= '0;
            quo      <= req.word ? {mag1[31:0], 32'b0} : mag1; // w form: top half first
        end else if (step) begin
            rem <= trial[`XLEN] ? rem_sh[`XLEN-1:0] : trial[`XLEN-1:0];
            quo <= {quo[`XLEN-2:0], ~trial[`XLEN]};
        end
    end

    assign q_fix = q_neg ? -quo : quo;
    assign r_fix = r_neg ? -rem : rem;

    always_comb begin
        if (dz_q) begin
            res = want_rem ? dividend : '1;
        end else if (ovf_q) begin
            res = want_rem ? '0 : dividend;
        end else begin
            res = want_rem ? r_fix : q_fix;
        end
        div_res = word_q ? {{(`XLEN-32){res[31]}}, res[31:0]} : res;
    end

endmodule

`default_nettype wire

//--- exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module exec_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue,
    input  rv_exec_pkg::insn_u     insn,
    input  logic [`XLEN-1:0]       rs1_val,
    input  logic [`XLEN-1:0]       rs2_val,
    output logic                   busy,
    output rv_exec_pkg::exec_rsp_t rsp
);

    rv_exec_pkg::alu_req_t req;
    logic [`XLEN-1:0]      alu_res;
    logic                  cmp_true;
    logic                  div_start;
    logic                  div_step;
    logic                  last_step;
    logic [`XLEN-1:0]      div_res;

    exec_decoder i_decoder (
        .insn    (insn),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .req     (req)
    );

    alu i_alu (
        .req      (req),
        .alu_res  (alu_res),
        .cmp_true (cmp_true)
    );

    exec_ctrl i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .req       (req),
        .alu_res   (alu_res),
        .cmp_true  (cmp_true),
        .last_step (last_step),
        .div_res   (div_res),
        .div_start (div_start),
        .div_step  (div_step),
        .busy      (busy),
        .rsp       (rsp)
    );

    div_step_counter i_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (div_start),
        .word      (req.word),
        .step      (div_step),
        .last_step (last_step)
    );

    div_datapath i_div (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (div_start),
        .step    (div_step),
        .req     (req),
        .div_res (div_res)
    );

endmodule

`default_nettype wire

//--- exec_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module exec_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   issue,
    input rv_exec_pkg::alu_req_t  req,
    input logic                   div_start,
    input logic                   div_step,
    input logic                   last_step,
    input logic                   busy,
    input rv_exec_pkg::exec_rsp_t rsp
);

    logic alu_accept;

    assign alu_accept = issue && !busy && !req.is_div;

    // a new single-cycle op may follow straight on
    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.valid && !alu_accept |=> !rsp.valid)
        else $error("response valid held for more than one cycle");

    busy_valid_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && rsp.valid))
        else $error("busy and response valid high together");

    // steps only follow a divide start or a step that was not the last
    no_idle_step: assert property (@(posedge clk) disable iff (!rst_n)
        div_step |-> $past(div_start) || $past(div_step && !last_step))
        else $error("divider step without a divide in progress");

    alu_latency: assert property (@(posedge clk) disable iff (!rst_n)
        alu_accept |=> rsp.valid)
        else $error("single-cycle op without a response on the next cycle");

endmodule

bind exec_ctrl exec_assertions i_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue),
    .req       (req),
    .div_start (div_start),
    .div_step  (div_step),
    .last_step (last_step),
    .busy      (busy),
    .rsp       (rsp)
);

`default_nettype wire

//--- exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_consts.svh"

module exec_tb;

    localparam int TIMEOUT = 200; // cycles per response

    logic                   clk;
    logic                   rst_n;
    logic                   issue;
    rv_exec_pkg::insn_u     insn;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    logic                   busy;
    rv_exec_pkg::exec_rsp_t rsp;

    int               checks;
    int               errors;
    int               test_errors;
    int               seed_ret;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;

    exec_unit i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (issue),
        .insn    (insn),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .busy    (busy),
        .rsp     (rsp)
    );

    always #20 clk = ~clk;

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [31:0] r_insn(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), opc};
    endfunction

    function automatic logic [31:0] i_insn(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {imm, 5'($urandom), f3, 5'($urandom), opc};
    endfunction

    // corner values mixed with plain random ones
    function automatic logic [63:0] rand_operand();
        case ($urandom % 8)
            0:       return 64'h0;
            1:       return '1;
            2:       return 64'h8000_0000_0000_0000;
            3:       return 64'h7fff_ffff_ffff_ffff;
            4:       return 64'($urandom % 16);
            5:       return sext32($urandom);
            default: return {$urandom, $urandom};
        endcase
    endfunction

    function automatic logic [31:0] rand_alu_insn();
        logic [2:0] f3;
        logic [5:0] sh;
        logic       alt;
        f3  = 3'($urandom);
        sh  = 6'($urandom);
        alt = 1'($urandom);
        case ($urandom % 5)
            0: return r_insn(alt && (f3 == 3'b000 || f3 == 3'b101) ? `F7_ALT : 7'b0,
                             f3, `OPC_OP);
            1: begin
                if (f3 == 3'b001) return i_insn({6'b0, sh}, f3, `OPC_OP_IMM);
                if (f3 == 3'b101) return i_insn({1'b0, alt, 4'b0, sh}, f3, `OPC_OP_IMM);
                return i_insn(12'($urandom), f3, `OPC_OP_IMM);
            end
            2: return r_insn(`F7_MULDIV, 3'b000, ($urandom % 2) ? `OPC_OP_32 : `OPC_OP);
            default: begin
                case ($urandom % 3) // only add, sll and srl/sra have word forms
                    0:       f3 = 3'b000;
                    1:       f3 = 3'b001;
                    default: f3 = 3'b101;
                endcase
                if ($urandom % 2 == 0) begin
                    return r_insn(alt && f3 != 3'b001 ? `F7_ALT : 7'b0, f3, `OPC_OP_32);
                end
                if (f3 == 3'b000) return i_insn(12'($urandom), f3, `OPC_OP_IMM_32);
                return i_insn({1'b0, alt && f3 == 3'b101, 5'b0, sh[4:0]}, f3, `OPC_OP_IMM_32);
            end
        endcase
    endfunction

    function automatic logic [31:0] rand_div_insn();
        return r_insn(`F7_MULDIV, {1'b1, 2'($urandom)}, ($urandom % 2) ? `OPC_OP_32 : `OPC_OP);
    endfunction

    function automatic logic [31:0] rand_branch_insn();
        logic [2:0] f3;
        f3 = 3'($urandom);
        if (f3[2:1] == 2'b01) f3[1] = 1'b0; // 010/011 are not branches
        return r_insn(7'($urandom), f3, `OPC_BRANCH);
    endfunction

    // riscv m-extension division, f3[0] unsigned, f3[1] remainder
    function automatic logic [63:0] divide(input logic [2:0] f3, input logic [63:0] a,
                                           input logic [63:0] b, input logic [63:0] min_neg);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = a;
        sb = b;
        if (b == 64'h0) return f3[1] ? a : '1;
        if (!f3[0] && a == min_neg && b == '1) return f3[1] ? 64'h0 : a;
        case (f3[1:0])
            2'b00:   return sa / sb;
            2'b01:   return a / b;
            2'b10:   return sa % sb;
            default: return a % b;
        endcase
    endfunction

    task automatic model(input logic [31:0] w, input logic [63:0] a, input logic [63:0] b,
                         output logic [63:0] rd, output logic taken);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        is_reg;
        logic        is_w;
        logic [63:0] op2;
        logic [5:0]  sh;
        opc    = w[6:0];
        f3     = w[14:12];
        is_reg = (opc == `OPC_OP) || (opc == `OPC_OP_32);
        is_w   = (opc == `OPC_OP_32) || (opc == `OPC_OP_IMM_32);
        op2    = is_reg ? b : {{52{w[31]}}, w[31:20]};
        sh     = is_w ? {1'b0, op2[4:0]} : op2[5:0];
        rd     = 64'h0;
        taken  = 1'b0;
        if (opc == `OPC_BRANCH) begin
            case (f3)
                3'b000:  taken = a == b;
                3'b001:  taken = a != b;
                3'b100:  taken = $signed(a) < $signed(b);
                3'b101:  taken = $signed(a) >= $signed(b);
                3'b110:  taken = a < b;
                default: taken = a >= b;
            endcase
        end else if (is_reg && w[31:25] == `F7_MULDIV) begin
            if (f3 == 3'b000) begin
                rd = a * op2;
            end else if (is_w) begin
                rd = divide(f3, f3[0] ? {32'h0, a[31:0]} : sext32(a[31:0]),
                            f3[0] ? {32'h0, b[31:0]} : sext32(b[31:0]), sext32(32'h8000_0000));
            end else begin
                rd = divide(f3, a, b, 64'h8000_0000_0000_0000);
            end
        end else begin
            case (f3)
                3'b000:  rd = (w[30] && is_reg) ? a - op2 : a + op2;
                3'b001:  rd = a << sh;
                3'b010:  rd = {63'b0, $signed(a) < $signed(op2)};
                3'b011:  rd = {63'b0, a < op2};
                3'b100:  rd = a ^ op2;
                3'b101: begin
                    if (is_w && w[30]) begin
                        rd = $signed(sext32(a[31:0])) >>> sh;
                    end else if (is_w) begin
                        rd = {32'h0, a[31:0]} >> sh;
                    end else if (w[30]) begin
                        rd = $signed(a) >>> sh;
                    end else begin
                        rd = a >> sh;
                    end
                end
                3'b110:  rd = a | op2;
                default: rd = a & op2;
            endcase
        end
        if (is_w) rd = sext32(rd[31:0]);
    endtask

    task automatic check_val(input string name, input string what, input logic [63:0] exp,
                             input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", name, what, exp, act);
            test_errors++;
        end
    endtask

    // drive one instruction and check its response; called 2 ns after an edge
    task automatic run_insn(input string name, input logic [31:0] w, input logic [63:0] a,
                            input logic [63:0] b);
        logic [63:0] exp_rd;
        logic        exp_taken;
        logic        is_div;
        int          exp_lat;
        int          cycles;
        model(w, a, b, exp_rd, exp_taken);
        is_div  = (w[6:0] == `OPC_OP || w[6:0] == `OPC_OP_32) && w[31:25] == `F7_MULDIV
                  && w[14];
        exp_lat = !is_div ? 0 : (w[6:0] == `OPC_OP_32 ? `DIV_STEPS_W : `DIV_STEPS_D) + 1;
        insn    = w;
        rs1_val = a;
        rs2_val = b;
        issue   = 1'b1;
        @(posedge clk);
        #2;
        issue  = 1'b0;
        cycles = 0;
        while (!rsp.valid && cycles < TIMEOUT) begin
            assert (!is_div || busy) else begin
                $display("%s: busy dropped before the divide response", name);
                test_errors++;
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!rsp.valid) begin
            $display("%s: no response within %0d cycles", name, TIMEOUT);
            $display("Testbench failed");
            $finish;
        end else begin
            check_val(name, "rd_val", exp_rd, rsp.rd_val);
            check_val(name, "taken", {63'b0, exp_taken}, {63'b0, rsp.taken});
            check_val(name, "latency", 64'(exp_lat), 64'(cycles));
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic finish_test(input string name, input int count);
        $display("test %s: %0d instructions, %0d errors", name, count, test_errors);
        errors      += test_errors;
        test_errors  = 0;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue       = 1'b0;
        insn        = '0;
        rs1_val     = '0;
        rs2_val     = '0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        seed_ret    = $urandom(32'he5b054d1);
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_val("reset", "busy", 64'h0, {63'b0, busy});
        check_val("reset", "valid", 64'h0, {63'b0, rsp.valid});
        repeat (8) begin
            idle_cycle();
            checks++;
            assert (!rsp.valid && !busy) else begin
                $display("reset: busy or response valid seen without an issue");
                test_errors++;
            end
        end
        finish_test("reset", 0);

        for (int n = 0; n < 200; n++) begin
            run_insn("alu", rand_alu_insn(), rand_operand(), rand_operand());
            idle_cycle();
        end
        finish_test("alu", 200);

        for (int n = 0; n < 120; n++) begin
            op_a = rand_operand();
            case ($urandom % 4)
                0:       op_b = op_a;
                1:       op_b = op_a + 64'd1;                   // unsigned wrap at all ones
                2:       op_b = op_a ^ 64'h8000_0000_0000_0000; // sign flip
                default: op_b = rand_operand();
            endcase
            run_insn("branch", rand_branch_insn(), op_a, op_b);
            idle_cycle();
        end
        finish_test("branch", 120);

        for (int n = 0; n < 80; n++) begin
            op_a = rand_operand();
            op_b = ($urandom % 2) ? 64'($urandom % 1000 + 1) : rand_operand();
            run_insn("divide", rand_div_insn(), op_a, op_b);
            idle_cycle();
        end
        finish_test("divide", 80);

        for (int f = 4; f < 8; f++) begin
            run_insn("div special", r_insn(`F7_MULDIV, 3'(f), `OPC_OP), rand_operand(), 64'h0);
            run_insn("div special", r_insn(`F7_MULDIV, 3'(f), `OPC_OP_32), rand_operand(),
                     {$urandom, 32'h0}); // upper half ignored by the w forms
            if (f[0] == 1'b0) begin
                run_insn("div special", r_insn(`F7_MULDIV, 3'(f), `OPC_OP),
                         64'h8000_0000_0000_0000, '1);
                run_insn("div special", r_insn(`F7_MULDIV, 3'(f), `OPC_OP_32),
                         {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff});
            end
        end
        finish_test("div special", 12);

        // next issue goes out in the cycle the response shows up
        for (int n = 0; n < 60; n++) begin
            if ($urandom % 3 == 0) begin
                run_insn("back-to-back", rand_div_insn(), rand_operand(), rand_operand());
            end else begin
                run_insn("back-to-back", rand_alu_insn(), rand_operand(), rand_operand());
            end
        end
        finish_test("back-to-back", 60);

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
rv_exec_pkg.sv
exec_decoder.sv
alu.sv
exec_ctrl.sv
div_step_counter.sv
div_datapath.sv
exec_unit.sv
exec_assertions.sv
exec_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the testbench, exit status follows the result
verilator --binary --assert --top-module exec_tb -f verilog.f -o exec_sim || exit 1
sim_out="$(./obj_dir/exec_sim)" && echo "$sim_out" \
    && echo "$sim_out" | grep -qx "Testbench passed" || exit 1
